/* source/lockstep_pkg.sv */
// Lockstep shared definitions

package lockstep_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Lockstep timing
  ////////////////////////////////////////////////////////////////////////////

  // Cycles the shadow core trails the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // Main results wait one extra cycle for the shadow output register
  localparam int unsigned OUTPUTS_OFFSET  = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_CNT_W    = (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Core widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W     = 16;
  localparam int unsigned INSTR_W    = 16;
  localparam int unsigned REG_ADDR_W = 2;
  localparam int unsigned NUM_REGS   = 4;
  localparam int unsigned IMM_W      = 8;
  // Shift amount taken from the low immediate bits
  localparam int unsigned SHIFT_W    = 4;
  localparam int unsigned MUBI_W     = 4;

  // Instruction field layout
  localparam int unsigned OPC_MSB = 15;
  localparam int unsigned OPC_LSB = 12;
  localparam int unsigned RD_MSB  = 11;
  localparam int unsigned RD_LSB  = 10;
  localparam int unsigned RS_MSB  = 9;
  localparam int unsigned RS_LSB  = 8;
  localparam int unsigned IMM_MSB = 7;
  localparam int unsigned IMM_LSB = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_NOP = 4'h0,
    OP_LDI = 4'h1,
    OP_ADD = 4'h2,
    OP_SUB = 4'h3,
    OP_AND = 4'h4,
    OP_XOR = 4'h5,
    OP_SHL = 4'h6
  } opcode_e;

  // Neither bitwise complements nor bit-reversals of each other
  typedef enum logic [MUBI_W-1:0] {
    MUBI_ON  = 4'b0101,
    MUBI_OFF = 4'b1100
  } mubi_e;

endpackage

/* source/lockstep_delay.sv */
// Resettable delay line

`timescale 1ns/1ps

module lockstep_delay #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] data_i,
  output logic [Width-1:0] data_o
);

  logic [Width-1:0] stage_q [Depth];

  // Stage 0 takes the input, the last stage drives the output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      for (int i = 1; i < Depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[Depth-1];

endmodule

/* source/lockstep_reset.sv */
// Shadow reset sequencer

`timescale 1ns/1ps

module lockstep_reset import lockstep_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  output logic shadow_rst_no,
  output logic cmp_enable_o
);

  localparam logic [OFFSET_CNT_W-1:0] CNT_MAX = OFFSET_CNT_W'(LOCKSTEP_OFFSET - 1);

  logic [OFFSET_CNT_W-1:0] cnt_q;
  mubi_e                   shadow_set_d;
  mubi_e                   shadow_set_q;
  mubi_e                   enable_cmp_q;

  // Counts up after reset and saturates one below the offset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CNT_MAX) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign shadow_set_d = (cnt_q == CNT_MAX) ? MUBI_ON : MUBI_OFF;

  ////////////////////////////////////////////////////////////////////////////
  // Release and enable flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_set_q <= MUBI_OFF;
      enable_cmp_q <= MUBI_OFF;
    end else begin
      shadow_set_q <= shadow_set_d;
      // Comparison starts one cycle after the shadow leaves reset
      enable_cmp_q <= shadow_set_q;
    end
  end

  assign shadow_rst_no = (shadow_set_q == MUBI_ON);

  // Any code other than OFF enables the comparison
  assign cmp_enable_o  = (enable_cmp_q != MUBI_OFF);

endmodule

/* source/core_decode.sv */
// Shadow core instruction decoder

`timescale 1ns/1ps

module core_decode import lockstep_pkg::*; (
  input  logic                  instr_valid_i,
  input  logic [INSTR_W-1:0]    instr_i,
  output opcode_e               op_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic [REG_ADDR_W-1:0] rs_o,
  output logic [IMM_W-1:0]      imm_o,
  output logic                  write_o
);

  logic [OPC_MSB-OPC_LSB:0] opc_raw;

  assign opc_raw = instr_i[OPC_MSB:OPC_LSB];

  // Register and immediate fields
  assign rd_o  = instr_i[RD_MSB:RD_LSB];
  assign rs_o  = instr_i[RS_MSB:RS_LSB];
  assign imm_o = instr_i[IMM_MSB:IMM_LSB];

  // Undefined codes fall back to NOP
  always_comb begin
    case (opc_raw)
      OP_LDI:  op_o = OP_LDI;
      OP_ADD:  op_o = OP_ADD;
      OP_SUB:  op_o = OP_SUB;
      OP_AND:  op_o = OP_AND;
      OP_XOR:  op_o = OP_XOR;
      OP_SHL:  op_o = OP_SHL;
      default: op_o = OP_NOP;
    endcase
  end

  // Every defined opcode except NOP writes rd
  assign write_o = instr_valid_i && (op_o != OP_NOP);

endmodule

/* source/core_execute.sv */
// Shadow core execute stage

`timescale 1ns/1ps

module core_execute import lockstep_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  opcode_e               op_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic [REG_ADDR_W-1:0] rs_i,
  input  logic [IMM_W-1:0]      imm_i,
  input  logic                  write_i,
  output logic                  res_valid_o,
  output logic [REG_ADDR_W-1:0] res_addr_o,
  output logic [DATA_W-1:0]     res_data_o
);

  logic [DATA_W-1:0] regs_q [NUM_REGS];
  logic [DATA_W-1:0] rd_val;
  logic [DATA_W-1:0] rs_val;
  logic [DATA_W-1:0] new_val;

  assign rd_val = regs_q[rd_i];
  assign rs_val = regs_q[rs_i];

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic unit
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      OP_LDI:  new_val = DATA_W'(imm_i);
      OP_ADD:  new_val = rd_val + rs_val;
      OP_SUB:  new_val = rd_val - rs_val;
      OP_AND:  new_val = rd_val & rs_val;
      OP_XOR:  new_val = rd_val ^ rs_val;
      OP_SHL:  new_val = rd_val << imm_i[SHIFT_W-1:0];
      default: new_val = rd_val;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_i) begin
      regs_q[rd_i] <= new_val;
    end
  end

  // Result port, address and data read zero on idle cycles
  // so they line up with an idle main-core result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
      res_addr_o  <= '0;
      res_data_o  <= '0;
    end else begin
      res_valid_o <= write_i;
      res_addr_o  <= write_i ? rd_i : '0;
      res_data_o  <= write_i ? new_val : '0;
    end
  end

endmodule

/* source/lockstep_compare.sv */
// Lockstep output comparator

`timescale 1ns/1ps

module lockstep_compare import lockstep_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmp_enable_i,
  input  logic                  shadow_valid_i,
  input  logic [REG_ADDR_W-1:0] shadow_addr_i,
  input  logic [DATA_W-1:0]     shadow_data_i,
  input  logic                  core_valid_i,
  input  logic [REG_ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0]     core_data_i,
  output logic                  alert_major_o
);

  logic                  shadow_valid_q;
  logic [REG_ADDR_W-1:0] shadow_addr_q;
  logic [DATA_W-1:0]     shadow_data_q;
  logic                  outputs_mismatch;

  // Shadow output register, matches the extra main-result stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_valid_q <= 1'b0;
      shadow_addr_q  <= '0;
      shadow_data_q  <= '0;
    end else begin
      shadow_valid_q <= shadow_valid_i;
      shadow_addr_q  <= shadow_addr_i;
      shadow_data_q  <= shadow_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////////////////////////////////////////

  assign outputs_mismatch =
    {shadow_valid_q, shadow_addr_q, shadow_data_q} != {core_valid_i, core_addr_i, core_data_i};

  assign alert_major_o = cmp_enable_i & outputs_mismatch;

endmodule

/* source/lockstep_top.sv */
// Lockstep shadow core top level

`timescale 1ns/1ps

module lockstep_top import lockstep_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  instr_valid_i,
  input  logic [INSTR_W-1:0]    instr_i,
  input  logic                  core_res_valid_i,
  input  logic [REG_ADDR_W-1:0] core_res_addr_i,
  input  logic [DATA_W-1:0]     core_res_data_i,
  output logic                  alert_major_o
);

  localparam int unsigned RES_W = 1 + REG_ADDR_W + DATA_W;

  logic                  shadow_rst_n;
  logic                  cmp_enable;

  // Delayed instruction stream
  logic                  dly_instr_valid;
  logic [INSTR_W-1:0]    dly_instr;

  // Decoded fields
  opcode_e               dec_op;
  logic [REG_ADDR_W-1:0] dec_rd;
  logic [REG_ADDR_W-1:0] dec_rs;
  logic [IMM_W-1:0]      dec_imm;
  logic                  dec_write;

  // Shadow core results
  logic                  shadow_res_valid;
  logic [REG_ADDR_W-1:0] shadow_res_addr;
  logic [DATA_W-1:0]     shadow_res_data;

  // Delayed main core results
  logic                  dly_res_valid;
  logic [REG_ADDR_W-1:0] dly_res_addr;
  logic [DATA_W-1:0]     dly_res_data;

  ////////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  ////////////////////////////////////////////////////////////////////////////

  lockstep_reset u_reset (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_enable_o  (cmp_enable)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Delay lines
  ////////////////////////////////////////////////////////////////////////////

  lockstep_delay #(
    .Width (INSTR_W + 1),
    .Depth (LOCKSTEP_OFFSET)
  ) u_instr_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({instr_valid_i, instr_i}),
    .data_o ({dly_instr_valid, dly_instr})
  );

  lockstep_delay #(
    .Width (RES_W),
    .Depth (OUTPUTS_OFFSET)
  ) u_result_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i ({core_res_valid_i, core_res_addr_i, core_res_data_i}),
    .data_o ({dly_res_valid, dly_res_addr, dly_res_data})
  );

  ////////////////////////////////////////////////////////////////////////////
  // Shadow core
  ////////////////////////////////////////////////////////////////////////////

  core_decode u_decode (
    .instr_valid_i (dly_instr_valid),
    .instr_i       (dly_instr),
    .op_o          (dec_op),
    .rd_o          (dec_rd),
    .rs_o          (dec_rs),
    .imm_o         (dec_imm),
    .write_o       (dec_write)
  );

  core_execute u_execute (
    .clk_i       (clk_i),
    .rst_ni      (shadow_rst_n),
    .op_i        (dec_op),
    .rd_i        (dec_rd),
    .rs_i        (dec_rs),
    .imm_i       (dec_imm),
    .write_i     (dec_write),
    .res_valid_o (shadow_res_valid),
    .res_addr_o  (shadow_res_addr),
    .res_data_o  (shadow_res_data)
  );

  // Comparator
  lockstep_compare u_compare (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmp_enable_i   (cmp_enable),
    .shadow_valid_i (shadow_res_valid),
    .shadow_addr_i  (shadow_res_addr),
    .shadow_data_i  (shadow_res_data),
    .core_valid_i   (dly_res_valid),
    .core_addr_i    (dly_res_addr),
    .core_data_i    (dly_res_data),
    .alert_major_o  (alert_major_o)
  );

endmodule

/* bench/lockstep_chk.sv */
// Lockstep sequencing checks

`timescale 1ns/1ps

module lockstep_chk import lockstep_pkg::*; (
  input logic clk_i,
  input logic rst_ni,
  input logic shadow_rst_ni,
  input logic cmp_enable_i,
  input logic alert_major_i
);

  localparam logic [OFFSET_CNT_W:0] HOLD_CYC = (OFFSET_CNT_W + 1)'(LOCKSTEP_OFFSET);

  int unsigned             fail_cnt = 0;
  logic [OFFSET_CNT_W:0]   since_rst_q;

  // Cycles since reset release, saturating at the offset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_rst_q <= '0;
    end else if (since_rst_q != HOLD_CYC) begin
      since_rst_q <= since_rst_q + 1'b1;
    end
  end

  alert_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !cmp_enable_i |-> !alert_major_i)
    else begin
      fail_cnt++;
      $error("Alert raised while the comparison is disabled");
    end

  shadow_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_rst_q < HOLD_CYC) |-> !shadow_rst_ni)
    else begin
      fail_cnt++;
      $error("Shadow core left reset too early");
    end

  enable_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(shadow_rst_ni) |=> $rose(cmp_enable_i))
    else begin
      fail_cnt++;
      $error("Compare enable did not rise one cycle after shadow release");
    end

endmodule

bind lockstep_top lockstep_chk u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .shadow_rst_ni (shadow_rst_n),
  .cmp_enable_i  (cmp_enable),
  .alert_major_i (alert_major_o)
);

/* bench/lockstep_tb.sv */
// Lockstep testbench

`timescale 1ns/1ps

module lockstep_tb import lockstep_pkg::*; ();

  // Columns of each data line are read in this order:
  // instr_valid instr core_res_valid core_res_addr core_res_data expect_alert
  localparam string       TRACE_FILE    = "bench/lockstep_trace.txt";
  localparam int unsigned RESET_CYCLES  = 2;
  localparam int unsigned MAX_STEPS     = 200;
  localparam int unsigned CLEAR_TIMEOUT = 10;
  localparam int unsigned NUM_PASSES    = 2;

  logic                  clk = 1'b0;
  logic                  rst_n = 1'b1;
  logic                  instr_valid = 1'b0;
  logic [INSTR_W-1:0]    instr = '0;
  logic                  res_valid = 1'b0;
  logic [REG_ADDR_W-1:0] res_addr = '0;
  logic [DATA_W-1:0]     res_data = '0;
  logic                  alert_major;

  // Expected alerts waiting for their compare cycle
  logic        exp_q [$];
  int unsigned errors = 0;
  int unsigned checks = 0;

  always #2 clk = ~clk;

  lockstep_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .instr_valid_i    (instr_valid),
    .instr_i          (instr),
    .core_res_valid_i (res_valid),
    .core_res_addr_i  (res_addr),
    .core_res_data_i  (res_data),
    .alert_major_o    (alert_major)
  );

  ////////////////////////////////////////////////////////////////////////////
  // One clock cycle of stimulus and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_step(input int unsigned           step,
                          input logic                  iv,
                          input logic [INSTR_W-1:0]    ins,
                          input logic                  rv,
                          input logic [REG_ADDR_W-1:0] ra,
                          input logic [DATA_W-1:0]     rd,
                          input logic                  ex);
    logic        exp_now;
    int unsigned waited;
    instr_valid = iv;
    instr       = ins;
    res_valid   = rv;
    res_addr    = ra;
    res_data    = rd;
    exp_q.push_back(ex);
    // Every pass opens with a reset, which must clear a pending alert
    rst_n = (step >= RESET_CYCLES);
    if (step == 0) begin
      waited = 0;
      do begin
        #0.1;
        waited++;
      end while (alert_major !== 1'b0 && waited < CLEAR_TIMEOUT);
      checks++;
      assert (alert_major === 1'b0) else begin
        errors++;
        $display("Alert still high %0d steps after reset was asserted", waited);
      end
    end
    @(posedge clk);
    #1;
    // A main result shows up in the alert OUTPUTS_OFFSET cycles after its line
    if (exp_q.size() >= int'(OUTPUTS_OFFSET)) begin
      exp_now = exp_q.pop_front();
    end else begin
      exp_now = 1'b0;
    end
    checks++;
    assert (alert_major === exp_now) else begin
      errors++;
      $display("MISMATCH alert_major_o expected %h got %h at step %0d, time %0t",
               exp_now, alert_major, step, $time);
    end
  endtask

  // Plays the whole trace once, starting with a reset
  task automatic play_trace(input int unsigned pass_no);
    int          fd;
    int          n;
    string       line;
    int unsigned step;
    int unsigned iter;
    logic [31:0] f_iv;
    logic [31:0] f_ins;
    logic [31:0] f_rv;
    logic [31:0] f_ra;
    logic [31:0] f_rd;
    logic [31:0] f_ex;
    exp_q.delete();
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open trace file %s", TRACE_FILE);
      return;
    end
    step = 0;
    iter = 0;
    while (!$feof(fd) && iter < MAX_STEPS) begin
      iter++;
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%h %h %h %h %h %h",
                           f_iv, f_ins, f_rv, f_ra, f_rd, f_ex) == 6) begin
        run_step(step, f_iv[0], f_ins[INSTR_W-1:0], f_rv[0],
                 f_ra[REG_ADDR_W-1:0], f_rd[DATA_W-1:0], f_ex[0]);
        step++;
      end
    end
    if (!$feof(fd)) begin
      errors++;
      $display("Trace reading timed out after %0d lines", MAX_STEPS);
    end
    $fclose(fd);
    // Idle cycles until the last traced result has been compared
    repeat (OUTPUTS_OFFSET - 1) begin
      run_step(step, 1'b0, '0, 1'b0, '0, '0, 1'b0);
      step++;
    end
    $display("Pass %0d done after %0d cycles", pass_no, step);
  endtask

  initial begin
    @(posedge clk);
    #1;
    // The second pass doubles as the mid-run reset
    for (int unsigned p = 1; p <= NUM_PASSES; p++) begin
      play_trace(p);
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_chk.fail_cnt);
    if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* bench/lockstep_trace.txt */
# instr_valid instr core_res_valid core_res_addr core_res_data expect_alert
# One line per cycle, all hex; the result column belongs to the previous line's instruction
# Reset window, instructions and results are ignored
1 1fff 1 3 beef 0
1 2500 1 2 1234 0
# Back-to-back LDI ADD SUB LDI AND XOR SHL
1 1012 0 0 0000 0
1 1434 1 0 0012 0
1 2100 1 1 0034 0
1 3400 1 0 0046 0
1 18f0 1 1 ffee 0
1 4900 1 2 00f0 0
1 5e00 1 2 00e0 0
1 6c04 1 3 00e0 0
# Idle gaps, a NOP and an undefined opcode
0 0000 1 3 0e00 0
0 0000 0 0 0000 0
1 0000 0 0 0000 0
1 f5aa 0 0 0000 0
1 1407 0 0 0000 0
1 2500 1 1 0007 0
# Data fault on r1
1 2400 1 1 000f 1
0 0000 1 1 0054 0
0 0000 0 0 0000 0
# Address fault
1 5000 0 0 0000 0
0 0000 1 2 0000 1
# Spurious strobe after a NOP
1 0000 0 0 0000 0
0 0000 1 0 0000 1
1 1c55 0 0 0000 0
1 6c01 1 3 0055 0
1 3e00 1 3 00aa 0
0 0000 1 3 ffca 0
# Last fault, still pending when the next reset arrives
1 1080 0 0 0000 0
0 0000 1 0 0081 1

/* flist.f */
source/lockstep_pkg.sv
source/lockstep_delay.sv
source/lockstep_reset.sv
source/core_decode.sv
source/core_execute.sv
source/lockstep_compare.sv
source/lockstep_top.sv
bench/lockstep_chk.sv
bench/lockstep_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the lockstep testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module lockstep_tb -o lockstep_sim
./obj_dir/lockstep_sim +verilator+error+limit+100 | tee sim.log
grep -qF "*** TEST PASSED ***" sim.log
echo "Simulation run finished"
